//--- include/pov_defines.svh
`ifndef POV_DEFINES_SVH
`define POV_DEFINES_SVH

// LED drivers on the rotor, one serial data lane each
`define POV_DRIVERS 30

// Channels per driver
`define POV_CHANNELS 16

// Grey level width, shifted MSB first
`define POV_GS_BITS 16

// Image columns per revolution, also the column mux width
`define POV_COLUMNS 8

// Driver configuration word
`define POV_CONF_BITS 48

// Cycles from latch to column advance
`define POV_BLANKING 72

// Pattern RAM address width
`define POV_ADDR_BITS 12

`endif

//--- verilog/pov_pkg.sv
`include "pov_defines.svh"

package pov_pkg;

   // One bit per driver lane for a single shift step
   typedef logic [`POV_DRIVERS-1:0] slice_t;

   // Pattern RAM read request
   typedef struct packed {
      logic [`POV_ADDR_BITS-1:0] addr;
      logic                      rd;
   } ram_req_t;

   // Shared driver control lines plus per-driver data lanes
   typedef struct packed {
      logic   gclk;
      logic   sclk;
      logic   lat;
      slice_t sin;
   } drv_bus_t;

   typedef logic [`POV_CONF_BITS-1:0] conf_t;

   // Logical lane i is routed to board pin lane_map[i]
   localparam logic [4:0] lane_map [`POV_DRIVERS] = '{
      5'd0,  5'd27, 5'd3,  5'd25, 5'd8,  5'd24, 5'd7,  5'd18, 5'd11, 5'd19,
      5'd4,  5'd28, 5'd1,  5'd29, 5'd13, 5'd22, 5'd9,  5'd16, 5'd10, 5'd15,
      5'd5,  5'd23, 5'd2,  5'd21, 5'd6,  5'd26, 5'd12, 5'd17, 5'd14, 5'd20
   };

endpackage

//--- verilog/slice_framebuffer.sv
`timescale 1ns/100ps
`include "pov_defines.svh"

module slice_framebuffer (
   input  logic                    clk_enable,
   input  logic                    nrst,
   input  logic                    position_sync,
   input  logic                    bit_taken,
   input  logic [`POV_GS_BITS-1:0] ram_data,
   output pov_pkg::ram_req_t       ram_req,
   output pov_pkg::slice_t         slice,
   output logic                    slice_valid,
   output logic                    column_start
);

   localparam int DRV_W  = $clog2(`POV_DRIVERS);
   localparam int CH_W   = $clog2(`POV_CHANNELS);
   localparam int BIT_W  = $clog2(`POV_GS_BITS);
   localparam int COL_W  = $clog2(`POV_COLUMNS);
   localparam int ADDR_W = `POV_ADDR_BITS;

   // Two channel buffers, channel c lives in buffer c[0]
   logic [`POV_GS_BITS-1:0] stage [2][`POV_DRIVERS];

   logic [COL_W-1:0]  col;
   logic [CH_W:0]     fill_ch;
   logic [DRV_W-1:0]  fill_drv;
   logic              fill_go;
   logic [DRV_W-1:0]  rd_drv;
   logic              rd_sel;
   logic              wr_valid;
   logic [DRV_W-1:0]  wr_drv;
   logic              wr_sel;
   logic [1:0]        full;
   logic [CH_W-1:0]   sh_ch;
   logic [BIT_W-1:0]  bit_cnt;
   logic              col_begin;
   logic              last_take;
   logic              start_col;
   logic              can_fill;
   logic [ADDR_W-1:0] fill_base;

   // Address of driver 0 for the channel being fetched
   assign fill_base = (ADDR_W'(col) * ADDR_W'(`POV_CHANNELS) + ADDR_W'(fill_ch))
                      * ADDR_W'(`POV_DRIVERS);

   assign can_fill  = !fill_go && (fill_ch < `POV_CHANNELS) && !full[fill_ch[0]];
   assign last_take = bit_taken && (bit_cnt == BIT_W'(`POV_GS_BITS - 1))
                      && (sh_ch == CH_W'(`POV_CHANNELS - 1));
   assign start_col = col_begin || position_sync || last_take;

   assign slice_valid = full[sh_ch[0]];

   always_comb begin
      for (int d = 0; d < `POV_DRIVERS; d++) begin
         slice[d] = stage[sh_ch[0]][d][`POV_GS_BITS - 1 - int'(bit_cnt)];
      end
   end

   always_ff @(posedge clk_enable) begin
      if (wr_valid) begin
         stage[wr_sel][wr_drv] <= ram_data;
      end
   end

   always_ff @(posedge clk_enable or negedge nrst) begin
      if (!nrst) begin
         ram_req      <= '0;
         column_start <= 1'b0;
         col_begin    <= 1'b1;
         col          <= '0;
         fill_ch      <= '0;
         fill_drv     <= '0;
         fill_go      <= 1'b0;
         rd_drv       <= '0;
         rd_sel       <= 1'b0;
         wr_valid     <= 1'b0;
         wr_drv       <= '0;
         wr_sel       <= 1'b0;
         full         <= '0;
         sh_ch        <= '0;
         bit_cnt      <= '0;
      end else begin
         column_start <= 1'b0;
         col_begin    <= 1'b0;
         ram_req.rd   <= 1'b0;
         // RAM answers one cycle after the strobe
         wr_valid     <= ram_req.rd;
         wr_drv       <= rd_drv;
         wr_sel       <= rd_sel;
         if (wr_valid && wr_drv == DRV_W'(`POV_DRIVERS - 1)) begin
            full[wr_sel] <= 1'b1;
         end
         if (bit_taken) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(`POV_GS_BITS - 1)) begin
               full[sh_ch[0]] <= 1'b0;
               sh_ch          <= sh_ch + 1'b1;
            end
         end
         if (fill_go) begin
            ram_req.rd   <= 1'b1;
            ram_req.addr <= fill_base + ADDR_W'(fill_drv);
            rd_drv       <= fill_drv;
            rd_sel       <= fill_ch[0];
            if (fill_drv == DRV_W'(`POV_DRIVERS - 1)) begin
               fill_go  <= 1'b0;
               fill_drv <= '0;
               fill_ch  <= fill_ch + 1'b1;
            end else begin
               fill_drv <= fill_drv + 1'b1;
            end
         end else if (can_fill) begin
            fill_go <= 1'b1;
         end
         if (start_col) begin
            column_start <= 1'b1;
            fill_ch      <= '0;
            fill_drv     <= '0;
            fill_go      <= 1'b0;
            full         <= '0;
            sh_ch        <= '0;
            bit_cnt      <= '0;
            if (position_sync) begin
               // Drop reads still in flight for the aborted column
               col        <= '0;
               ram_req.rd <= 1'b0;
               wr_valid   <= 1'b0;
            end else if (last_take) begin
               col <= (col == COL_W'(`POV_COLUMNS - 1)) ? '0 : col + 1'b1;
            end
         end
      end
   end

endmodule

//--- verilog/driver_controller.sv
`timescale 1ns/100ps
`include "pov_defines.svh"

module driver_controller (
   input  logic              clk_enable,
   input  logic              nrst,
   input  logic              position_sync,
   input  pov_pkg::slice_t   slice,
   input  logic              slice_valid,
   input  logic              column_start,
   input  logic              new_configuration_ready,
   input  pov_pkg::conf_t    serialized_conf,
   output logic              bit_taken,
   output logic              column_done,
   output pov_pkg::drv_bus_t drv
);

   localparam int PIX_BITS = `POV_CHANNELS * `POV_GS_BITS;
   localparam int CNT_W    = $clog2(PIX_BITS);
   localparam int BLANK_W  = $clog2(`POV_BLANKING);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CONF,
      ST_SHIFT,
      ST_LATCH,
      ST_BLANK
   } state_t;

   state_t             state;
   logic [CNT_W-1:0]   bit_cnt;
   logic [BLANK_W-1:0] blank_cnt;
   logic               phase;
   logic               lat_cnt;
   logic               conf_mode;
   logic               conf_pend;
   logic               col_pend;
   pov_pkg::conf_t     conf_sr;
   logic               last_bit;
   logic               abort;

   assign last_bit = conf_mode ? (bit_cnt == CNT_W'(`POV_CONF_BITS - 1))
                               : (bit_cnt == CNT_W'(PIX_BITS - 1));

   // A configuration load runs to completion, pixel work is dropped
   assign abort = position_sync && (state != ST_CONF)
                  && !(state == ST_LATCH && conf_mode);

   always_ff @(posedge clk_enable or negedge nrst) begin
      if (!nrst) begin
         state       <= ST_IDLE;
         drv         <= '0;
         bit_taken   <= 1'b0;
         column_done <= 1'b0;
         bit_cnt     <= '0;
         blank_cnt   <= '0;
         phase       <= 1'b0;
         lat_cnt     <= 1'b0;
         conf_mode   <= 1'b0;
         conf_pend   <= 1'b0;
         col_pend    <= 1'b0;
         conf_sr     <= '0;
      end else begin
         drv.gclk    <= ~drv.gclk;
         bit_taken   <= 1'b0;
         column_done <= 1'b0;
         if (new_configuration_ready) begin
            conf_pend <= 1'b1;
         end
         if (column_start) begin
            col_pend <= 1'b1;
         end
         if (abort) begin
            state    <= ST_IDLE;
            drv.sclk <= 1'b0;
            drv.lat  <= 1'b0;
            phase    <= 1'b0;
            bit_cnt  <= '0;
            col_pend <= 1'b0;
         end else begin
            case (state)
               ST_IDLE: begin
                  drv.lat <= 1'b0;
                  // Configuration has priority between columns
                  if (conf_pend || new_configuration_ready) begin
                     state     <= ST_CONF;
                     conf_mode <= 1'b1;
                     conf_sr   <= serialized_conf;
                     conf_pend <= 1'b0;
                  end else if (col_pend || column_start) begin
                     state     <= ST_SHIFT;
                     conf_mode <= 1'b0;
                     col_pend  <= 1'b0;
                  end
               end
               ST_CONF, ST_SHIFT: begin
                  if (!phase) begin
                     drv.sclk <= 1'b0;
                     if (conf_mode) begin
                        drv.sin <= {`POV_DRIVERS{conf_sr[`POV_CONF_BITS-1]}};
                        conf_sr <= conf_sr << 1;
                        phase   <= 1'b1;
                     end else if (slice_valid) begin
                        drv.sin   <= slice;
                        bit_taken <= 1'b1;
                        phase     <= 1'b1;
                     end
                  end else begin
                     drv.sclk <= 1'b1;
                     phase    <= 1'b0;
                     bit_cnt  <= bit_cnt + 1'b1;
                     if (last_bit) begin
                        state   <= ST_LATCH;
                        bit_cnt <= '0;
                     end
                  end
               end
               ST_LATCH: begin
                  drv.sclk <= 1'b0;
                  drv.lat  <= 1'b1;
                  // Pixel latch is one cycle, configuration latch two
                  if (!conf_mode || lat_cnt) begin
                     state     <= conf_mode ? ST_IDLE : ST_BLANK;
                     lat_cnt   <= 1'b0;
                     blank_cnt <= '0;
                  end else begin
                     lat_cnt <= 1'b1;
                  end
               end
               ST_BLANK: begin
                  drv.lat   <= 1'b0;
                  blank_cnt <= blank_cnt + 1'b1;
                  if (blank_cnt == BLANK_W'(`POV_BLANKING - 1)) begin
                     column_done <= 1'b1;
                     state       <= ST_IDLE;
                  end
               end
               default: begin
                  state <= ST_IDLE;
               end
            endcase
         end
      end
   end

endmodule

//--- verilog/column_mux.sv
`timescale 1ns/100ps
`include "pov_defines.svh"

module column_mux (
   input  logic                    clk_enable,
   input  logic                    nrst,
   input  logic                    position_sync,
   input  logic                    column_done,
   output logic [`POV_COLUMNS-1:0] mux_out
);

   localparam logic [`POV_COLUMNS-1:0] FIRST_COL = `POV_COLUMNS'(1);

   // One-hot select, bit k drives column k
   always_ff @(posedge clk_enable or negedge nrst) begin
      if (!nrst) begin
         mux_out <= FIRST_COL;
      end else if (position_sync) begin
         mux_out <= FIRST_COL;
      end else if (column_done) begin
         mux_out <= {mux_out[`POV_COLUMNS-2:0], mux_out[`POV_COLUMNS-1]};
      end
   end

endmodule

//--- verilog/pov_display_top.sv
`timescale 1ns/100ps
`include "pov_defines.svh"

module pov_display_top (
   input  logic                    clk_enable,
   input  logic                    nrst,
   input  logic                    position_sync,
   input  logic                    new_configuration_ready,
   input  pov_pkg::conf_t          serialized_conf,
   input  logic [`POV_GS_BITS-1:0] ram_data,
   output pov_pkg::ram_req_t       ram_req,
   output pov_pkg::drv_bus_t       drv,
   output logic [`POV_COLUMNS-1:0] mux_out
);

   pov_pkg::slice_t   slice;
   logic              slice_valid;
   logic              column_start;
   logic              bit_taken;
   logic              column_done;
   pov_pkg::drv_bus_t drv_logical;

   slice_framebuffer u_slice_framebuffer (
      .clk_enable    (clk_enable),
      .nrst          (nrst),
      .position_sync (position_sync),
      .bit_taken     (bit_taken),
      .ram_data      (ram_data),
      .ram_req       (ram_req),
      .slice         (slice),
      .slice_valid   (slice_valid),
      .column_start  (column_start)
   );

   driver_controller u_driver_controller (
      .clk_enable              (clk_enable),
      .nrst                    (nrst),
      .position_sync           (position_sync),
      .slice                   (slice),
      .slice_valid             (slice_valid),
      .column_start            (column_start),
      .new_configuration_ready (new_configuration_ready),
      .serialized_conf         (serialized_conf),
      .bit_taken               (bit_taken),
      .column_done             (column_done),
      .drv                     (drv_logical)
   );

   column_mux u_column_mux (
      .clk_enable    (clk_enable),
      .nrst          (nrst),
      .position_sync (position_sync),
      .column_done   (column_done),
      .mux_out       (mux_out)
   );

   // Board routing of the data lanes
   always_comb begin
      drv = drv_logical;
      for (int i = 0; i < `POV_DRIVERS; i++) begin
         drv.sin[pov_pkg::lane_map[i]] = drv_logical.sin[i];
      end
   end

endmodule

//--- tb/tb_pov_display.sv
`timescale 1ns/100ps
`include "pov_defines.svh"

module tb_pov_display;

   localparam int PIX_BITS = `POV_CHANNELS * `POV_GS_BITS;
   localparam int TIMEOUT  = 12 * 900 + 2000;

   logic                    clk_enable = 1'b0;
   logic                    nrst;
   logic                    position_sync;
   logic                    new_configuration_ready;
   pov_pkg::conf_t          serialized_conf;
   logic [`POV_GS_BITS-1:0] ram_data;
   pov_pkg::ram_req_t       ram_req;
   pov_pkg::drv_bus_t       drv;
   logic [`POV_COLUMNS-1:0] mux_out;

   logic [31:0]     rnd_state = 32'hbea5e266;
   logic [31:0]     ram_base;
   pov_pkg::slice_t shifted [PIX_BITS];
   int              bits = 0;
   int              lat_len = 0;
   logic            lat_is_conf = 1'b0;
   logic            prev_sclk = 1'b0;
   logic            prev_lat = 1'b0;
   logic            prev_gclk = 1'b0;
   logic            prev_nrst = 1'b0;
   logic            mux_due = 1'b0;
   int              exp_col = 0;
   int              pix_latches = 0;
   int              conf_latches = 0;
   int              value_errors = 0;
   int              other_errors = 0;
   int              cycles = 0;

   pov_display_top u_pov_display_top (
      .clk_enable              (clk_enable),
      .nrst                    (nrst),
      .position_sync           (position_sync),
      .new_configuration_ready (new_configuration_ready),
      .serialized_conf         (serialized_conf),
      .ram_data                (ram_data),
      .ram_req                 (ram_req),
      .drv                     (drv),
      .mux_out                 (mux_out)
   );

   always #50 clk_enable = ~clk_enable;

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic get_random(input int n, output logic [47:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         rnd_state = lfsr_step(rnd_state);
         v = {v[46:0], rnd_state[0]};
      end
   endtask

   // Pattern RAM contents, seeded per test from ram_base
   function automatic logic [15:0] pixel_value(input logic [`POV_ADDR_BITS-1:0] addr);
      logic [31:0] s;
      logic [15:0] v;
      s = ram_base ^ ({20'h0, addr} * 32'h9e3779b1);
      if (s == '0) begin
         s = 32'hbea5e266;
      end
      v = '0;
      for (int i = 0; i < 16; i++) begin
         s = lfsr_step(s);
         v = {v[14:0], s[0]};
      end
      return v;
   endfunction

   // Channel 0 first, each grey level MSB first
   function automatic pov_pkg::slice_t expected_slice(input int col, input int step);
      pov_pkg::slice_t s;
      logic [15:0]     level;
      int              ch;
      int              b;
      ch = step / `POV_GS_BITS;
      b = `POV_GS_BITS - 1 - step % `POV_GS_BITS;
      for (int d = 0; d < `POV_DRIVERS; d++) begin
         level = pixel_value(`POV_ADDR_BITS'((col * `POV_CHANNELS + ch) * `POV_DRIVERS + d));
         s[d] = level[b];
      end
      return s;
   endfunction

   task automatic compare_slice(input string name, input pov_pkg::slice_t exp,
                                input pov_pkg::slice_t got);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_conf(input string name, input pov_pkg::conf_t exp,
                               input pov_pkg::conf_t got);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_mux(input string name, input logic [`POV_COLUMNS-1:0] exp,
                              input logic [`POV_COLUMNS-1:0] got);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
      end
   endtask

   // Control lines low and column 0 selected
   task automatic check_reset_outputs(input string when);
      compare_bit({"drv.sclk ", when}, 1'b0, drv.sclk);
      compare_bit({"drv.lat ", when}, 1'b0, drv.lat);
      compare_bit({"drv.gclk ", when}, 1'b0, drv.gclk);
      compare_bit({"ram_req.rd ", when}, 1'b0, ram_req.rd);
      compare_mux({"mux_out ", when}, `POV_COLUMNS'(1), mux_out);
   endtask

   task automatic print_counts();
      $display("Errors: %0d wrong values, %0d other failures, %0d pixel and %0d conf latches",
               value_errors, other_errors, pix_latches, conf_latches);
   endtask

   // RAM answers one cycle after the strobe
   always @(posedge clk_enable) begin
      if (ram_req.rd) begin
         ram_data <= pixel_value(ram_req.addr);
      end
   end

   // Driver model, sampled away from the active edge
   always @(negedge clk_enable) begin
      pov_pkg::slice_t s;
      pov_pkg::conf_t  got;
      if (nrst) begin
         if (prev_nrst) begin
            compare_bit("drv.gclk", ~prev_gclk, drv.gclk);
         end
         if (drv.sclk && !prev_sclk) begin
            for (int i = 0; i < `POV_DRIVERS; i++) begin
               s[i] = drv.sin[pov_pkg::lane_map[i]];
            end
            if (bits < PIX_BITS) begin
               shifted[bits] = s;
            end else begin
               other_errors++;
               $display("More than %0d shift bits before a latch at %0t", PIX_BITS, $time);
            end
            bits++;
            if (mux_due) begin
               compare_mux("mux_out", `POV_COLUMNS'(1) << exp_col, mux_out);
               mux_due = 1'b0;
            end
         end
         if (drv.lat && !prev_lat) begin
            lat_len = 1;
            if (bits == PIX_BITS) begin
               lat_is_conf = 1'b0;
               for (int j = 0; j < PIX_BITS; j++) begin
                  compare_slice($sformatf("drv.sin column %0d step %0d", exp_col, j),
                                expected_slice(exp_col, j), shifted[j]);
               end
               compare_mux("mux_out at latch", `POV_COLUMNS'(1) << exp_col, mux_out);
               exp_col = (exp_col + 1) % `POV_COLUMNS;
               mux_due = 1'b1;
               pix_latches++;
            end else if (bits == `POV_CONF_BITS) begin
               lat_is_conf = 1'b1;
               for (int j = 0; j < `POV_CONF_BITS; j++) begin
                  compare_slice($sformatf("drv.sin conf step %0d", j),
                                {`POV_DRIVERS{serialized_conf[`POV_CONF_BITS-1-j]}}, shifted[j]);
                  got[`POV_CONF_BITS-1-j] = shifted[j][0];
               end
               compare_conf("conf word", serialized_conf, got);
               conf_latches++;
            end else begin
               other_errors++;
               $display("Latch after %0d shift bits at %0t", bits, $time);
            end
            bits = 0;
         end else if (drv.lat) begin
            lat_len++;
         end
         if (!drv.lat && prev_lat && lat_len != (lat_is_conf ? 2 : 1)) begin
            other_errors++;
            $display("Latch pulse lasted %0d cycles at %0t", lat_len, $time);
         end
         // Partial column is thrown away on sync
         if (position_sync) begin
            bits = 0;
            exp_col = 0;
            mux_due = 1'b1;
         end
      end
      prev_sclk = drv.sclk;
      prev_lat = drv.lat;
      prev_gclk = drv.gclk;
      prev_nrst = nrst;
   end

   always @(posedge clk_enable) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         other_errors++;
         $display("Timeout after %0d cycles", cycles);
         print_counts();
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic wait_pixel(input int n);
      int target;
      target = pix_latches + n;
      while (pix_latches < target) begin
         @(posedge clk_enable);
      end
   endtask

   // Pulse a configuration word and wait for its latch
   task automatic load_conf(input pov_pkg::conf_t value, input int cols_first);
      int conf_target;
      int pix_start;
      conf_target = conf_latches + 1;
      pix_start = pix_latches;
      serialized_conf <= value;
      new_configuration_ready <= 1'b1;
      @(posedge clk_enable);
      new_configuration_ready <= 1'b0;
      while (conf_latches < conf_target) begin
         @(posedge clk_enable);
      end
      if (pix_latches - pix_start != cols_first) begin
         other_errors++;
         $display("Configuration latched after %0d column latches instead of %0d at %0t",
                  pix_latches - pix_start, cols_first, $time);
      end
   endtask

   // New RAM contents take effect together with the restart at column 0
   task automatic restart_image();
      logic [47:0] r;
      get_random(32, r);
      ram_base = r[31:0] | 32'h1;
      position_sync <= 1'b1;
      @(posedge clk_enable);
      position_sync <= 1'b0;
      @(negedge clk_enable);
      compare_mux("mux_out after sync", `POV_COLUMNS'(1), mux_out);
      @(posedge clk_enable);
   endtask

   initial begin
      logic [47:0] r;
      nrst = 1'b0;
      position_sync = 1'b0;
      new_configuration_ready = 1'b0;
      serialized_conf = '0;
      ram_data = '0;
      ram_base = 32'h1234abcd;

      // Reset state
      repeat (5) @(negedge clk_enable);
      check_reset_outputs("in reset");
      repeat (5) @(posedge clk_enable);
      nrst <= 1'b1;
      @(negedge clk_enable);
      check_reset_outputs("after reset");

      // Full revolution plus wrap to column 0
      wait_pixel(9);

      // Configuration pending during a column, then taken while idle
      restart_image();
      wait_pixel(1);
      repeat (200) @(posedge clk_enable);
      load_conf(48'ha5c3_0f1e_7b29, 1);
      @(negedge clk_enable);
      while (drv.lat) begin
         @(negedge clk_enable);
      end
      while (!drv.lat) begin
         @(negedge clk_enable);
      end
      // Lands on the idle cycle after blanking
      repeat (`POV_BLANKING) @(posedge clk_enable);
      load_conf(48'h3c96_e107_d45a, 0);

      // Sync in mid-column
      repeat (150) @(posedge clk_enable);
      restart_image();
      wait_pixel(1);

      // Configuration loads at random points delay the pixel stream
      restart_image();
      for (int i = 0; i < 2; i++) begin
         wait_pixel(1);
         get_random(8, r);
         repeat (100 + int'(r[7:0])) @(posedge clk_enable);
         get_random(48, r);
         load_conf(r, 1);
      end

      print_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+include
verilog/pov_pkg.sv
verilog/slice_framebuffer.sv
verilog/driver_controller.sv
verilog/column_mux.sv
verilog/pov_display_top.sv
tb/tb_pov_display.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the POV display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
   --top-module tb_pov_display -f flist.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see build.log"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "All tests passed" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
